// File: vlog.f
+incdir+.
soc_bus_pkg.sv
bus_fsm.sv
machine_timer.sv
ram_store.sv
plic_regs.sv
soc_bus_top.sv
tb_soc_bus.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_soc_bus
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_soc_bus.sv
`timescale 1ns/10ps
`include "soc_bus_macros.svh"

module tb_soc_bus import soc_bus_pkg::*; ();

    localparam int clk_period = 20;
    localparam int n_dwords   = 8;
    localparam int timer_wait = 1000;
    localparam int mtip_limit = `TIMER_TICK_DIV * 4;
    // cycle budget of all tests together
    localparam int test_cycles = n_dwords * 120 + timer_wait + mtip_limit + 200;

    logic                   CLOCK_50;
    logic                   KEY0 = 1'b0;
    logic                   bus_read_enable = 1'b0;
    logic                   bus_write_enable = 1'b0;
    logic [`BUS_ADDR_W-1:0] bus_address = '0;
    ls_type_e               bus_ls_type = ls_lw;
    logic [`BUS_DATA_W-1:0] bus_write_data = '0;
    logic                   irq_source = 1'b0;
    logic [`BUS_DATA_W-1:0] bus_read_data;
    logic                   bus_read_done;
    logic                   bus_write_done;
    irq_t                   irq;

    logic [7:0] model [0:`RAM_BYTES-1];  // byte image of the RAM
    integer     seed = 32'ha2e9094c;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         cycle_count = 0;
    string      test_name;

    soc_bus_top u_dut (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #(clk_period / 2) CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) cycle_count <= cycle_count + 1;

    // a done flag only falls in the cycle after its enable
    read_done_drop: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(bus_read_done) |-> $past(bus_read_enable))
        else begin
            errors++;
            $display("read done fell without a read enable at cycle %0d", cycle_count);
        end

    write_done_drop: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(bus_write_done) |-> $past(bus_write_enable))
        else begin
            errors++;
            $display("write done fell without a write enable at cycle %0d", cycle_count);
        end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    function automatic logic in_ram(input logic [31:0] addr);
        return (addr >= `RAM_BASE) && (addr < `RAM_BASE + `RAM_BYTES);
    endfunction

    // little endian gather from the byte image with sign extension for signed types
    function automatic logic [63:0] model_load(input logic [31:0] addr, input ls_type_e ls);
        logic [63:0] v;
        int          n;
        v = '0;
        n = 1 << ls[1:0];
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model[addr - `RAM_BASE + i];
        end
        if (!ls[2]) begin
            for (int b = 8 * n; b < 64; b++) begin
                v[b] = v[8*n-1];
            end
        end
        return v;
    endfunction

    // one request with a wait for its done flag and a latency check
    task automatic access(input logic rd, input logic [31:0] addr, input ls_type_e ls,
                          input logic [63:0] wdata, output logic [63:0] rdata);
        int cycles;
        int latency;
        cycles  = 0;
        latency = (in_ram(addr) && ls == ls_ld) ? 3 : 2;  // ld and sd take two RAM steps
        @(posedge CLOCK_50);
        #2;
        bus_read_enable  = rd;
        bus_write_enable = !rd;
        bus_address      = addr;
        bus_ls_type      = ls;
        bus_write_data   = wdata;
        do begin
            @(posedge CLOCK_50);
            #2;
            bus_read_enable  = 1'b0;
            bus_write_enable = 1'b0;
            cycles++;
        end while (!(rd ? bus_read_done : bus_write_done) && cycles < 10);
        rdata = bus_read_data;
        check_value($sformatf("latency at %h", addr), 64'(latency), 64'(cycles));
    endtask

    task automatic store(input logic [31:0] addr, input ls_type_e ls, input logic [63:0] data);
        logic [63:0] ignored;
        access(1'b0, addr, ls, data, ignored);
        if (in_ram(addr)) begin
            for (int i = 0; i < (1 << ls[1:0]); i++) begin
                model[addr - `RAM_BASE + i] = data[8*i +: 8];
            end
        end
    endtask

    task automatic load_check(input logic [31:0] addr, input ls_type_e ls);
        logic [63:0] data;
        access(1'b1, addr, ls, '0, data);
        check_value($sformatf("%s at %h", ls.name(), addr), model_load(addr, ls), data);
    endtask

    task automatic read_check(input string what, input logic [31:0] addr, input ls_type_e ls,
                              input logic [63:0] expected);
        logic [63:0] data;
        access(1'b1, addr, ls, '0, data);
        check_value(what, expected, data);
    endtask

    task automatic finish_test(input int errors_before);
        tests++;
        $display("test %-10s %s", test_name, (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] addr;
        logic [63:0] t0;
        logic [63:0] t1;
        logic [63:0] cmp_value;
        int          c0;
        int          waited;
        int          start_err;
        repeat (3) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;

        test_name = "widths";
        start_err = errors;
        check_value("done flags", 64'd3, {bus_read_done, bus_write_done});
        check_value("irq", 64'd0, irq);
        for (int k = 0; k < n_dwords; k++) begin
            addr = `RAM_BASE + 32'($unsigned($random(seed)) % (`RAM_BYTES / 8)) * 8;
            store(addr, ls_sd, {$random(seed), $random(seed)});
            load_check(addr, ls_ld);
            for (int b = 0; b < 8; b++) begin
                load_check(addr + b, ls_lb);
                load_check(addr + b, ls_lbu);
                if (b % 2 == 0) begin
                    load_check(addr + b, ls_lh);
                    load_check(addr + b, ls_lhu);
                end
                if (b % 4 == 0) begin
                    load_check(addr + b, ls_lw);
                    load_check(addr + b, ls_lwu);
                end
            end
        end
        finish_test(start_err);

        test_name = "narrow";
        start_err = errors;
        addr = `RAM_BASE + 32'h40;
        store(addr, ls_sw, 64'h1122_3344);
        store(addr + 4, ls_sw, 64'h5566_7788);  // neighbour word
        store(addr + 1, ls_sb, 64'hab);
        load_check(addr, ls_lw);
        store(addr + 2, ls_sh, 64'hcdef);
        store(addr + 3, ls_sb, 64'h99);
        read_check("merged word", addr, ls_lwu, 64'h99ef_ab44);
        load_check(addr + 4, ls_lw);
        finish_test(start_err);

        test_name = "timer";
        start_err = errors;
        read_check("mtimecmp reset", `MTIMECMP_ADDR, ls_ld, 64'h0000_0000_8000_0000);
        access(1'b1, `MTIME_ADDR, ls_ld, '0, t0);
        c0 = cycle_count;
        repeat (timer_wait) @(posedge CLOCK_50);
        access(1'b1, `MTIME_ADDR, ls_ld, '0, t1);
        c0 = (cycle_count - c0) / `TIMER_TICK_DIV;  // expected ticks
        waited = int'(t1 - t0);
        checks++;
        assert (waited >= c0 - 1 && waited <= c0 + 1) else begin
            errors++;
            $display("** Error %s mtime advance: expected %0d +-1, actual %0d",
                     test_name, c0, waited);
        end
        access(1'b1, `MTIME_ADDR, ls_ld, '0, t0);
        cmp_value = t0 + 2;
        store(`MTIMECMP_ADDR, ls_sd, cmp_value);
        read_check("mtimecmp write", `MTIMECMP_ADDR, ls_ld, cmp_value);
        waited = 0;
        while (!irq.mtip && waited < mtip_limit) begin
            @(posedge CLOCK_50);
            #2;
            waited++;
        end
        checks++;
        assert (irq.mtip) else begin
            errors++;
            $display("%s: mtip did not rise within %0d cycles", test_name, mtip_limit);
        end
        finish_test(start_err);

        test_name = "plic";
        start_err = errors;
        store(`PLIC_BASE + 4, ls_sw, 64'd5);
        read_check("priority 1", `PLIC_BASE + 4, ls_lw, 64'd5);
        store(`PLIC_BASE + `PLIC_THRESHOLD_OFF + `PLIC_CTX_STEP, ls_sw, 64'd3);
        read_check("threshold ctx1", `PLIC_BASE + `PLIC_THRESHOLD_OFF + `PLIC_CTX_STEP,
                   ls_lw, 64'd3);
        store(`PLIC_BASE + `PLIC_ENABLE_OFF, ls_sw, 64'h2);
        read_check("enable ctx0", `PLIC_BASE + `PLIC_ENABLE_OFF, ls_lw, 64'h2);
        read_check("pending idle", `PLIC_BASE + `PLIC_PENDING_OFF, ls_lw, 64'd0);
        @(posedge CLOCK_50);
        #2;
        irq_source = 1'b1;
        @(posedge CLOCK_50);
        #2;
        irq_source = 1'b0;
        @(posedge CLOCK_50);
        #2;
        check_value("meip,msip after edge", 64'b10, {irq.meip, irq.msip});
        read_check("pending set", `PLIC_BASE + `PLIC_PENDING_OFF, ls_lw, 64'h2);
        read_check("claim ctx0", `PLIC_BASE + `PLIC_CLAIM_OFF, ls_lw, 64'd1);
        check_value("meip after claim", 64'd0, irq.meip);
        read_check("second claim", `PLIC_BASE + `PLIC_CLAIM_OFF, ls_lw, 64'd0);
        finish_test(start_err);

        test_name = "unmapped";
        start_err = errors;
        read_check("mtimecmp", `MTIMECMP_ADDR, ls_ld, cmp_value);  // nonzero data first
        read_check("unmapped read", 32'h4000_0040, ls_ld, 64'd0);
        store(32'h4000_0040, ls_sd, 64'hdead_beef_dead_beef);
        read_check("mtimecmp kept", `MTIMECMP_ADDR, ls_ld, cmp_value);
        read_check("enable kept", `PLIC_BASE + `PLIC_ENABLE_OFF, ls_lw, 64'h2);
        load_check(`RAM_BASE + 32'h40, ls_lw);
        finish_test(start_err);

        test_name = "handshake";
        start_err = errors;
        addr = `RAM_BASE + 32'h40;
        @(posedge CLOCK_50);
        #2;
        bus_read_enable = 1'b1;
        bus_address     = addr;
        bus_ls_type     = ls_lw;
        @(posedge CLOCK_50);
        #2;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b1;  // lands while the read is busy
        bus_write_data   = 64'h0bad_0bad;
        @(posedge CLOCK_50);
        #2;
        bus_write_enable = 1'b0;
        check_value("read done", 64'd1, bus_read_done);
        check_value("write done held", 64'd1, bus_write_done);
        check_value("first result", model_load(addr, ls_lw), bus_read_data);
        load_check(addr, ls_lw);
        finish_test(start_err);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(20 * test_cycles * clk_period);
        $display("watchdog expired at cycle %0d, the run did not finish", cycle_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: soc_bus_top.sv
`timescale 1ns/10ps
`include "soc_bus_macros.svh"

module soc_bus_top import soc_bus_pkg::*; (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    input  logic [`BUS_ADDR_W-1:0] bus_address,
    input  ls_type_e               bus_ls_type,
    input  logic [`BUS_DATA_W-1:0] bus_write_data,
    output logic [`BUS_DATA_W-1:0] bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done,
    input  logic                   irq_source,
    output irq_t                   irq
);

    bus_req_t               req;
    target_sel_t            sel;
    logic                   strobe;
    logic                   word_step;
    logic [31:0]            ram_word;
    logic [31:0]            plic_word;
    logic [`BUS_DATA_W-1:0] mtime;
    logic [`BUS_DATA_W-1:0] mtimecmp;
    logic                   meip;
    logic                   msip;
    logic                   mtip;

    bus_fsm u_bus_fsm (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_address      (bus_address),
        .bus_ls_type      (bus_ls_type),
        .bus_write_data   (bus_write_data),
        .ram_word         (ram_word),
        .plic_word        (plic_word),
        .mtime            (mtime),
        .mtimecmp         (mtimecmp),
        .req              (req),
        .sel              (sel),
        .strobe           (strobe),
        .word_step        (word_step),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done)
    );

    machine_timer u_machine_timer (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (req),
        .sel      (sel),
        .strobe   (strobe),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .mtip     (mtip)
    );

    ram_store u_ram_store (
        .CLOCK_50  (CLOCK_50),
        .req       (req),
        .sel       (sel),
        .strobe    (strobe),
        .word_step (word_step),
        .ram_word  (ram_word)
    );

    plic_regs u_plic_regs (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .sel        (sel),
        .strobe     (strobe),
        .irq_source (irq_source),
        .plic_word  (plic_word),
        .meip       (meip),
        .msip       (msip)
    );

    assign irq = '{meip: meip, msip: msip, mtip: mtip};

endmodule

// File: plic_regs.sv
`timescale 1ns/10ps
`include "soc_bus_macros.svh"

module plic_regs import soc_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  bus_req_t    req,
    input  target_sel_t sel,
    input  logic        strobe,
    input  logic        irq_source,
    output logic [31:0] plic_word,
    output logic        meip,
    output logic        msip
);

    localparam int n_src = `PLIC_SOURCES;
    localparam int id_w  = $clog2(n_src);

    logic [2:0]             prio      [1:n_src-1];
    logic [n_src-1:0]       pending;
    logic [n_src-1:0]       enable    [2];
    logic [2:0]             threshold [2];
    logic [31:0]            claim     [2];
    logic                   src_q;
    logic [`PLIC_OFF_W-1:0] off;
    logic [id_w-1:0]        prio_id;
    logic                   hit_prio;
    logic                   hit_pend;
    logic [1:0]             hit_en;
    logic [1:0]             hit_thr;
    logic [1:0]             hit_claim;

    assign off      = sel.plic_off;
    assign prio_id  = off[id_w+1:2];
    assign hit_prio = sel.plic && (off < n_src * 4) && (prio_id != 0) && (off[1:0] == 2'd0);
    assign hit_pend = sel.plic && (off == `PLIC_PENDING_OFF);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            hit_en[c]    = sel.plic && (off == `PLIC_ENABLE_OFF + c * `PLIC_ENABLE_CTX_STEP);
            hit_thr[c]   = sel.plic && (off == `PLIC_THRESHOLD_OFF + c * `PLIC_CTX_STEP);
            hit_claim[c] = sel.plic && (off == `PLIC_CLAIM_OFF + c * `PLIC_CTX_STEP);
            claim[c]     = (pending[1] && enable[c][1]) ? 32'd1 : 32'd0;  // only id 1 exists
        end
    end

    assign meip = (claim[0] != 0);
    assign msip = (claim[1] != 0);

    always_comb begin
        plic_word = '0;
        if (hit_prio) plic_word = {29'd0, prio[prio_id]};
        if (hit_pend) plic_word = {{(32-n_src){1'b0}}, pending};
        for (int c = 0; c < 2; c++) begin
            if (hit_en[c])    plic_word = {{(32-n_src){1'b0}}, enable[c]};
            if (hit_thr[c])   plic_word = {29'd0, threshold[c]};
            if (hit_claim[c]) plic_word = claim[c];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 1; i < n_src; i++) prio[i] <= '0;
            pending   <= '0;
            enable    <= '{default: '0};
            threshold <= '{default: '0};
            src_q     <= 1'b0;
        end else begin
            src_q <= irq_source;
            if (strobe && req.wr) begin
                if (hit_prio) prio[prio_id] <= req.wdata[2:0];
                for (int c = 0; c < 2; c++) begin
                    if (hit_en[c])  enable[c]    <= req.wdata[n_src-1:0];
                    if (hit_thr[c]) threshold[c] <= req.wdata[2:0];
                end
            end
            // claim read completes the interrupt
            if (strobe && req.rd) begin
                for (int c = 0; c < 2; c++) begin
                    if (hit_claim[c] && claim[c] != 0) pending[1] <= 1'b0;
                end
            end
            if (irq_source && !src_q) pending[1] <= 1'b1;  // new edge wins over a claim
        end
    end

endmodule

// File: ram_store.sv
`timescale 1ns/10ps
`include "soc_bus_macros.svh"

module ram_store import soc_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  bus_req_t    req,
    input  target_sel_t sel,
    input  logic        strobe,
    input  logic        word_step,
    output logic [31:0] ram_word
);

    localparam int idx_w = $clog2(`RAM_WORDS);

    logic [31:0]            mem [0:`RAM_WORDS-1];
    logic [`BUS_ADDR_W-1:0] offset;
    logic [idx_w-1:0]       idx;
    logic [1:0]             lane;
    logic [3:0]             byte_en;
    logic [31:0]            wr_lanes;
    logic [31:0]            rd_word;
    logic [31:0]            shifted;
    logic                   sign_ext;

    assign offset = req.addr - `RAM_BASE;
    assign idx    = offset[idx_w+1:2] + idx_w'(word_step);  // step 1 is the next word
    assign lane   = req.addr[1:0];

    // lane enables and replicated store data
    always_comb begin
        byte_en  = '0;
        wr_lanes = '0;
        case (req.ls_type)
            ls_sb: begin
                byte_en[lane] = 1'b1;
                wr_lanes      = {4{req.wdata[7:0]}};
            end
            ls_sh: begin
                byte_en  = lane[1] ? 4'b1100 : 4'b0011;
                wr_lanes = {2{req.wdata[15:0]}};
            end
            ls_sw: begin
                byte_en  = 4'b1111;
                wr_lanes = req.wdata[31:0];
            end
            ls_sd: begin
                byte_en  = 4'b1111;
                wr_lanes = word_step ? req.wdata[63:32] : req.wdata[31:0];
            end
            default: byte_en = '0;  // unsigned codes are loads only
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (strobe && sel.ram && req.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[idx][8*b +: 8] <= wr_lanes[8*b +: 8];
                end
            end
        end
    end

    // load path, size from bits [1:0], sign from bit 2
    always_comb begin
        rd_word  = mem[idx];
        shifted  = rd_word >> {lane, 3'b000};
        sign_ext = ~req.ls_type[2];
        case (req.ls_type[1:0])
            2'd0:    ram_word = {{24{sign_ext & shifted[7]}}, shifted[7:0]};
            2'd1:    ram_word = {{16{sign_ext & shifted[15]}}, shifted[15:0]};
            default: ram_word = rd_word;  // lw, lwu and each half of ld
        endcase
    end

endmodule

// File: machine_timer.sv
`timescale 1ns/10ps
`include "soc_bus_macros.svh"

module machine_timer import soc_bus_pkg::*; (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  bus_req_t               req,
    input  target_sel_t            sel,
    input  logic                   strobe,
    output logic [`BUS_DATA_W-1:0] mtime,
    output logic [`BUS_DATA_W-1:0] mtimecmp,
    output logic                   mtip
);

    localparam int div_w = $clog2(`TIMER_TICK_DIV);

    logic [div_w-1:0] prescale;
    logic             tick;

    assign tick = (prescale == div_w'(`TIMER_TICK_DIV - 1));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            prescale <= '0;
            mtime    <= '0;
            mtimecmp <= `MTIMECMP_RESET;
            mtip     <= 1'b0;
        end else begin
            prescale <= tick ? '0 : prescale + 1'b1;
            if (strobe && req.wr && sel.mtime) begin
                mtime <= req.wdata;  // software write beats the tick
            end else if (tick) begin
                mtime <= mtime + 1'b1;
            end
            if (strobe && req.wr && sel.mtimecmp) begin
                mtimecmp <= req.wdata;
            end
            mtip <= (mtime >= mtimecmp);
        end
    end

endmodule

// File: bus_fsm.sv
`timescale 1ns/10ps
`include "soc_bus_macros.svh"

module bus_fsm import soc_bus_pkg::*; (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   bus_read_enable,
    input  logic                   bus_write_enable,
    input  logic [`BUS_ADDR_W-1:0] bus_address,
    input  ls_type_e               bus_ls_type,
    input  logic [`BUS_DATA_W-1:0] bus_write_data,
    input  logic [31:0]            ram_word,
    input  logic [31:0]            plic_word,
    input  logic [`BUS_DATA_W-1:0] mtime,
    input  logic [`BUS_DATA_W-1:0] mtimecmp,
    output bus_req_t               req,
    output target_sel_t            sel,
    output logic                   strobe,
    output logic                   word_step,
    output logic [`BUS_DATA_W-1:0] bus_read_data,
    output logic                   bus_read_done,
    output logic                   bus_write_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_serve,
        st_serve_hi
    } state_e;

    state_e                 state;
    logic                   accept;
    logic                   two_step;
    logic                   ext_fill;
    logic [`BUS_DATA_W-1:0] serve_data;

    function automatic target_sel_t decode(input logic [`BUS_ADDR_W-1:0] a);
        target_sel_t      s;
        logic [`BUS_ADDR_W-1:0] poff;
        s          = '0;
        poff       = a - `PLIC_BASE;
        s.ram      = (a >= `RAM_BASE) && (a < `RAM_BASE + `RAM_BYTES);
        s.mtime    = (a == `MTIME_ADDR);
        s.mtimecmp = (a == `MTIMECMP_ADDR);
        s.plic     = (a >= `PLIC_BASE) && (a < `PLIC_BASE + `PLIC_SIZE);
        s.plic_off = poff[`PLIC_OFF_W-1:0];
        return s;  // all zero for an unmapped address
    endfunction

    // new requests only when both done flags are high
    assign accept    = (state == st_idle) && (bus_read_enable || bus_write_enable);
    assign two_step  = sel.ram && (req.ls_type == ls_ld);  // ld and sd share the code
    assign strobe    = (state != st_idle);
    assign word_step = (state == st_serve_hi);

    // 32 to 64 bit extension, signed types only
    assign ext_fill = ram_word[31] & ~req.ls_type[2];

    always_comb begin
        serve_data = '0;  // unmapped reads return zero
        if (sel.ram) begin
            serve_data = {{32{ext_fill}}, ram_word};
        end else if (sel.mtime) begin
            serve_data = mtime;
        end else if (sel.mtimecmp) begin
            serve_data = mtimecmp;
        end else if (sel.plic) begin
            serve_data = {32'd0, plic_word};
        end
    end

    // request and decode held for the whole access
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            req <= '{addr: bus_address, ls_type: bus_ls_type, wdata: bus_write_data,
                     rd: bus_read_enable, wr: bus_write_enable};
            sel <= decode(bus_address);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= st_idle;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state          <= st_serve;
                        bus_read_done  <= ~bus_read_enable;
                        bus_write_done <= ~bus_write_enable;
                    end
                end
                st_serve: begin
                    if (two_step) begin
                        state <= st_serve_hi;  // upper word next
                    end else begin
                        state          <= st_idle;
                        bus_read_done  <= 1'b1;
                        bus_write_done <= 1'b1;
                    end
                end
                st_serve_hi: begin
                    state          <= st_idle;
                    bus_read_done  <= 1'b1;
                    bus_write_done <= 1'b1;
                end
                default: state <= st_idle;
            endcase

            if (strobe && req.rd) begin
                if (!two_step) begin
                    bus_read_data <= serve_data;
                end else if (word_step) begin
                    bus_read_data[63:32] <= ram_word;  // high word second
                end else begin
                    bus_read_data[31:0] <= ram_word;
                end
            end
        end
    end

endmodule

// File: soc_bus_pkg.sv
`include "soc_bus_macros.svh"

package soc_bus_pkg;

    // bits [1:0] give the size, bit 2 marks an unsigned load
    typedef enum logic [2:0] {
        ls_lb  = 3'b000,
        ls_lh  = 3'b001,
        ls_lw  = 3'b010,
        ls_ld  = 3'b011,
        ls_lbu = 3'b100,
        ls_lhu = 3'b101,
        ls_lwu = 3'b110
    } ls_type_e;

    // stores share the signed load codes
    localparam ls_type_e ls_sb = ls_lb;
    localparam ls_type_e ls_sh = ls_lh;
    localparam ls_type_e ls_sw = ls_lw;
    localparam ls_type_e ls_sd = ls_ld;

    typedef struct packed {
        logic [`BUS_ADDR_W-1:0] addr;
        ls_type_e               ls_type;
        logic [`BUS_DATA_W-1:0] wdata;
        logic                   rd;
        logic                   wr;
    } bus_req_t;

    typedef struct packed {
        logic                   ram;
        logic                   mtime;
        logic                   mtimecmp;
        logic                   plic;
        logic [`PLIC_OFF_W-1:0] plic_off;  // byte offset from PLIC_BASE
    } target_sel_t;

    typedef struct packed {
        logic meip;
        logic msip;
        logic mtip;
    } irq_t;

endpackage

// File: soc_bus_macros.svh
`ifndef SOC_BUS_MACROS_SVH
`define SOC_BUS_MACROS_SVH

// processor port widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 64

// on-chip RAM, 32-bit words
`define RAM_BASE  32'h8000_0000
`define RAM_WORDS 2048
`define RAM_BYTES (`RAM_WORDS * 4)

// machine timer registers
`define MTIME_ADDR     32'h0200_BFF8
`define MTIMECMP_ADDR  32'h0200_4000
`define MTIMECMP_RESET 64'h0000_0000_8000_0000
`define TIMER_TICK_DIV 50  // clocks per mtime tick

// interrupt controller window and register offsets
`define PLIC_BASE  32'h0C00_0000
`define PLIC_SIZE  32'h0040_0000
`define PLIC_OFF_W 22  // offset bits inside the window

`define PLIC_PENDING_OFF     32'h0000_1000
`define PLIC_ENABLE_OFF      32'h0000_2000
`define PLIC_ENABLE_CTX_STEP 32'h0000_0080  // enable block per context
`define PLIC_THRESHOLD_OFF   32'h0020_0000
`define PLIC_CLAIM_OFF       32'h0020_0004
`define PLIC_CTX_STEP        32'h0000_1000  // threshold/claim per context

// source 0 is reserved, external source is id 1
`define PLIC_SOURCES 6

`endif
